/* include/i2s_defines.svh */
//////////////////////////////
// format constants for the i2s transmitter
// included by the package and by the modules that size counters
//////////////////////////////

`ifndef I2S_DEFINES_SVH
`define I2S_DEFINES_SVH

//////////////////////////////
// audio word format
//////////////////////////////

// active bits per channel, sent msb first
`define I2S_SAMPLE_BITS 16

// bit slots per channel half-frame
// one delay slot, the active bits, then pad
`define I2S_SLOT_BITS 32

//////////////////////////////
// clock ratio
//////////////////////////////

// mclk cycles per bit clock period
`define I2S_MCLK_PER_SCLK 4

`endif

/* verilog/i2s_pkg.sv */
//////////////////////////////
// shared types for the i2s transmitter
// imported by wildcard in every module header
//////////////////////////////

`include "i2s_defines.svh"

package i2s_pkg;

    // one signed channel sample
    typedef logic signed [`I2S_SAMPLE_BITS-1:0] sample_t;

    // bit slot index inside a half-frame
    typedef logic [$clog2(`I2S_SLOT_BITS)-1:0] slot_idx_t;

    // channel follows the lrck level, low is left
    typedef enum logic {
        CH_LEFT  = 1'b0,
        CH_RIGHT = 1'b1
    } channel_e;

    // what the current slot carries
    // slot 0 delay, slots 1..16 data, rest pad
    typedef enum logic [1:0] {
        SLOT_DELAY = 2'd0,
        SLOT_DATA  = 2'd1,
        SLOT_PAD   = 2'd2
    } slot_phase_e;

endpackage

/* verilog/sample_latch.sv */
//////////////////////////////
// input side of the i2s transmitter
// holds one pending stereo pair and hands it over at frame start
// flags underrun and overrun as single-cycle pulses
//////////////////////////////

`timescale 1ns/1ps

module sample_latch import i2s_pkg::*; (
    input  logic    audgen_mclk,
    input  logic    reset_n,

    // incoming pair with its strobe
    input  sample_t sample_left,
    input  sample_t sample_right,
    input  logic    sample_valid,

    // from the frame timer
    input  logic    frame_start,

    // words for the frame being played
    output sample_t play_left,
    output sample_t play_right,
    output logic    underrun,
    output logic    overrun
);

    sample_t pend_left;
    sample_t pend_right;
    logic    pending;

    //////////////////////////////
    // pending pair
    //////////////////////////////

    // a new strobe always overwrites, no back-pressure
    always_ff @(posedge audgen_mclk) begin
        if (sample_valid) begin
            pend_left  <= sample_left;
            pend_right <= sample_right;
        end
    end

    // strobe on the frame_start cycle belongs to the next frame
    // so it wins over the clear
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
        end else if (sample_valid) begin
            pending <= 1'b1;
        end else if (frame_start) begin
            pending <= 1'b0;
        end
    end

    //////////////////////////////
    // handover and flags
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            // first frame after reset plays silence
            play_left  <= '0;
            play_right <= '0;
            underrun   <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            underrun <= 1'b0;
            // second strobe before the handover replaced a pair
            overrun  <= sample_valid && pending && !frame_start;
            if (frame_start) begin
                if (pending) begin
                    play_left  <= pend_left;
                    play_right <= pend_right;
                end else begin
                    // nothing arrived, send silence
                    play_left  <= '0;
                    play_right <= '0;
                    underrun   <= 1'b1;
                end
            end
        end
    end

    // the two flags come from different events and never overlap
    a_flags_exclusive: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !(underrun && overrun)
    );

endmodule

/* verilog/i2s_frame_timer.sv */
//////////////////////////////
// i2s frame timing from the master audio clock
// divides mclk into sclk, counts slots, toggles lrck
// and marks the last bit of each frame
//////////////////////////////

`timescale 1ns/1ps

`include "i2s_defines.svh"

module i2s_frame_timer import i2s_pkg::*; (
    input  logic        audgen_mclk,
    input  logic        reset_n,

    output logic        audio_sclk,
    output logic        audio_lrck,

    // one mclk cycle before every falling sclk
    output logic        bit_tick,
    output slot_idx_t   slot_idx,
    output channel_e    channel,
    output slot_phase_e slot_phase,
    output logic        frame_start
);

    typedef logic [$clog2(`I2S_MCLK_PER_SCLK)-1:0] mclk_div_t;

    mclk_div_t mclk_div;
    logic      last_slot;

    //////////////////////////////
    // bit clock
    //////////////////////////////

    // free running divider, 0..3
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div <= '0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
        end
    end

    // msb of the divider, low two cycles then high two
    assign audio_sclk = mclk_div[$bits(mclk_div)-1];

    // last mclk of the sclk period, sclk falls on the next edge
    assign bit_tick = (mclk_div == mclk_div_t'(`I2S_MCLK_PER_SCLK - 1));

    //////////////////////////////
    // slots and channel
    //////////////////////////////

    assign last_slot = (slot_idx == slot_idx_t'(`I2S_SLOT_BITS - 1));

    // slot and lrck move together with the sclk falling edge
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_idx <= '0;
            channel  <= CH_LEFT;
        end else if (bit_tick) begin
            slot_idx <= slot_idx + 1'b1;
            if (last_slot) begin
                channel <= (channel == CH_LEFT) ? CH_RIGHT : CH_LEFT;
            end
        end
    end

    assign audio_lrck = channel;

    // slot classification
    always_comb begin
        if (slot_idx == '0) begin
            slot_phase = SLOT_DELAY;
        end else if (slot_idx <= slot_idx_t'(`I2S_SAMPLE_BITS)) begin
            slot_phase = SLOT_DATA;
        end else begin
            slot_phase = SLOT_PAD;
        end
    end

    // last tick of the right half, left half starts next edge
    assign frame_start = bit_tick && last_slot && (channel == CH_RIGHT);

    //////////////////////////////
    // checks
    //////////////////////////////

    // slot counter wraps into left slot 0 on the falling sclk
    a_start_to_left: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        frame_start |=> (channel == CH_LEFT) && (slot_idx == '0) && !audio_sclk
    );

    // lrck may only move on a falling sclk
    a_lrck_after_tick: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $past(bit_tick) && $fell(audio_sclk)
    );

endmodule

/* verilog/i2s_serializer.sv */
//////////////////////////////
// output side of the i2s transmitter
// loads the channel word after the delay slot
// and shifts it out msb first on each falling sclk
//////////////////////////////

`timescale 1ns/1ps

`include "i2s_defines.svh"

module i2s_serializer import i2s_pkg::*; (
    input  logic        audgen_mclk,
    input  logic        reset_n,

    // timing from the frame timer
    input  logic        bit_tick,
    input  slot_phase_e slot_phase,
    input  channel_e    channel,

    // words from the sample latch
    input  sample_t     play_left,
    input  sample_t     play_right,

    output logic        audio_dac
);

    typedef logic [$clog2(`I2S_SAMPLE_BITS)-1:0] bit_cnt_t;

    sample_t                     cur_word;
    logic [`I2S_SAMPLE_BITS-2:0] shreg;
    bit_cnt_t                    bits_left;

    // word for the half-frame in progress
    assign cur_word = (channel == CH_LEFT) ? play_left : play_right;

    //////////////////////////////
    // shift register
    //////////////////////////////

    // dac holds the bit for the slot after the tick
    // msb goes out directly, the rest waits in shreg
    always_ff @(posedge audgen_mclk) begin
        if (bit_tick) begin
            if (slot_phase == SLOT_DELAY) begin
                shreg <= cur_word[`I2S_SAMPLE_BITS-2:0];
            end else if (slot_phase == SLOT_DATA) begin
                shreg <= {shreg[`I2S_SAMPLE_BITS-3:0], 1'b0};
            end
        end
    end

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            audio_dac <= 1'b0;
            bits_left <= '0;
        end else if (bit_tick) begin
            case (slot_phase)
                SLOT_DELAY: begin
                    // end of delay slot, start the word
                    audio_dac <= cur_word[`I2S_SAMPLE_BITS-1];
                    bits_left <= bit_cnt_t'(`I2S_SAMPLE_BITS - 1);
                end
                SLOT_DATA: begin
                    if (bits_left != '0) begin
                        audio_dac <= shreg[`I2S_SAMPLE_BITS-2];
                        bits_left <= bits_left - 1'b1;
                    end else begin
                        // lsb was the last data slot, pad follows
                        audio_dac <= 1'b0;
                    end
                end
                default: begin
                    // pad slots, and the delay slot that follows them
                    audio_dac <= 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // registered dac has to line up with the decoded phase
    a_dac_quiet: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (slot_phase != SLOT_DATA) |-> !audio_dac
    );

endmodule

/* verilog/i2s_tx_top.sv */
//////////////////////////////
// i2s audio transmitter, top level
// stereo pairs in with a strobe, i2s stream out on mclk
//////////////////////////////

`timescale 1ns/1ps

module i2s_tx_top import i2s_pkg::*; (
    input  logic    audgen_mclk,
    input  logic    reset_n,

    input  sample_t sample_left,
    input  sample_t sample_right,
    input  logic    sample_valid,

    output logic    audio_sclk,
    output logic    audio_lrck,
    output logic    audio_dac,
    output logic    underrun,
    output logic    overrun
);

    logic        bit_tick;
    slot_idx_t   slot_idx;
    channel_e    channel;
    slot_phase_e slot_phase;
    logic        frame_start;
    sample_t     play_left;
    sample_t     play_right;

    // frame timing
    i2s_frame_timer i2s_frame_timer_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .bit_tick    (bit_tick),
        .slot_idx    (slot_idx),
        .channel     (channel),
        .slot_phase  (slot_phase),
        .frame_start (frame_start)
    );

    // pending pair and handover
    sample_latch sample_latch_inst (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .sample_valid (sample_valid),
        .frame_start  (frame_start),
        .play_left    (play_left),
        .play_right   (play_right),
        .underrun     (underrun),
        .overrun      (overrun)
    );

    // dac shifter
    i2s_serializer i2s_serializer_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .bit_tick    (bit_tick),
        .slot_phase  (slot_phase),
        .channel     (channel),
        .play_left   (play_left),
        .play_right  (play_right),
        .audio_dac   (audio_dac)
    );

    // handover lands in left slot 0, well before the word is loaded
    a_underrun_at_left_start: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        underrun |-> (channel == CH_LEFT) && (slot_idx == '0)
    );

endmodule

/* test/tb_clock_gen.sv */
//////////////////////////////
// testbench clock and reset
// 10 ns mclk, reset low for 16 cycles
//////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
    output logic audgen_mclk,
    output logic reset_n
);

    initial begin
        audgen_mclk = 1'b0;
        forever #5 audgen_mclk = ~audgen_mclk;
    end

    // release a little after the edge, like other inputs
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge audgen_mclk);
        #1 reset_n = 1'b1;
    end

endmodule

/* test/tb_i2s_tx.sv */
//////////////////////////////
// testbench for the i2s transmitter
// random pairs strobed in the right half, decoded back from the dac line
// checks words, delay and pad slots, clock ratio, underrun and overrun
//////////////////////////////

`timescale 1ns/1ps

module tb_i2s_tx;

    // frames 0..39 random, 40 empty, 41 two strobes, 42 one, 43 empty
    localparam int  NF       = 44;
    localparam time WATCHDOG = (NF + 4) * 256 * 10;

    logic        audgen_mclk;
    logic        reset_n;
    logic [15:0] sample_left;
    logic [15:0] sample_right;
    logic        sample_valid;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;
    logic        underrun;
    logic        overrun;

    integer      seed = 32'h419cf886;
    int          err_cnt [0:5];
    int          check_cnt;
    // expected words and flag counts per decoded frame
    logic [15:0] exp_left [0:NF];
    logic [15:0] exp_right [0:NF];
    int          exp_under [0:NF];
    int          exp_over [0:NF];
    // decoder state
    int          dec_frames;
    int          slot;
    logic        first_sclk;
    logic        prev_lrck;
    logic [15:0] word;
    logic [15:0] dec_left;
    time         last_sclk;
    int          un_total;
    int          un_snap;
    int          ov_total;
    int          ov_snap;

    tb_clock_gen tb_clock_gen_inst (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n)
    );

    i2s_tx_top i2s_tx_top_inst (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .sample_valid (sample_valid),
        .audio_sclk   (audio_sclk),
        .audio_lrck   (audio_lrck),
        .audio_dac    (audio_dac),
        .underrun     (underrun),
        .overrun      (overrun)
    );

    // cat picks the test the check belongs to
    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, input int cat);
        check_cnt++;
        if (got !== exp) begin
            err_cnt[cat]++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int cat);
        $display("%s: %s, %0d errors", name, (err_cnt[cat] == 0) ? "ok" : "errors",
                 err_cnt[cat]);
    endtask

    //////////////////////////////
    // flag pulse counters
    //////////////////////////////

    always @(posedge audgen_mclk) begin
        if (reset_n) begin
            if (underrun) un_total++;
            if (overrun) ov_total++;
        end
    end

    //////////////////////////////
    // i2s decoder model
    //////////////////////////////

    // dac is stable on rising sclk, mid slot
    // sclk stays low through reset
    always @(posedge audio_sclk) begin
        // sclk period is 4 mclk
        if (!first_sclk) compare("audio_sclk period", 32'($time - last_sclk), 32'd40, 1);
        last_sclk = $time;
        if (first_sclk || audio_lrck != prev_lrck) begin
            // lrck moves only after 32 slots
            if (!first_sclk) compare("audio_lrck slots per half", 32'(slot), 32'd31, 1);
            slot = 0;
        end else begin
            slot++;
        end
        first_sclk = 1'b0;
        prev_lrck  = audio_lrck;
        if (slot >= 1 && slot <= 16) begin
            word = {word[14:0], audio_dac};
        end else begin
            compare("audio_dac in delay/pad slot", {31'd0, audio_dac}, 32'd0, 3);
        end
        if (slot == 31 && !audio_lrck) begin
            dec_left = word;
        end else if (slot == 31 && audio_lrck && dec_frames <= NF) begin
            // frame complete, check against the model
            compare("left word", {16'd0, dec_left}, {16'd0, exp_left[dec_frames]},
                    (dec_frames == 41 || dec_frames == NF) ? 4 : (dec_frames == 42) ? 5 : 2);
            compare("right word", {16'd0, word}, {16'd0, exp_right[dec_frames]},
                    (dec_frames == 41 || dec_frames == NF) ? 4 : (dec_frames == 42) ? 5 : 2);
            compare("underrun pulses", 32'(un_total - un_snap),
                    32'(exp_under[dec_frames]), 4);
            compare("overrun pulses", 32'(ov_total - ov_snap),
                    32'(exp_over[dec_frames]), 5);
            un_snap = un_total;
            ov_snap = ov_total;
            dec_frames++;
        end
    end

    // hung or stalled stream
    initial begin
        #(WATCHDOG);
        $display("watchdog expired before all frames were decoded");
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////
    // stimulus and report
    //////////////////////////////

    task automatic strobe_pair(input int f);
        logic [31:0] r;
        repeat (4) @(posedge audgen_mclk);
        r = $random(seed);
        #1;
        sample_left  = r[15:0];
        sample_right = r[31:16];
        sample_valid = 1'b1;
        // last strobe of the right half is the one played next frame
        exp_left[f+1]  = r[15:0];
        exp_right[f+1] = r[31:16];
        @(posedge audgen_mclk);
        #1 sample_valid = 1'b0;
    endtask

    initial begin
        int errors;
        sample_left  = '0;
        sample_right = '0;
        sample_valid = 1'b0;
        check_cnt = 0;
        dec_frames = 0;
        un_total = 0;
        un_snap = 0;
        ov_total = 0;
        ov_snap = 0;
        // decoder starts at left slot 0 on the first rising sclk
        first_sclk = 1'b1;
        prev_lrck = 1'b0;
        slot = 0;
        word = '0;
        last_sclk = 0;
        for (int i = 0; i < 6; i++) err_cnt[i] = 0;
        for (int i = 0; i <= NF; i++) begin
            exp_left[i]  = '0;
            exp_right[i] = '0;
            exp_under[i] = 0;
            exp_over[i]  = 0;
        end

        // outputs quiet inside and just after reset
        repeat (8) @(posedge audgen_mclk);
        #1;
        compare("audio_sclk", {31'd0, audio_sclk}, 32'd0, 0);
        compare("audio_lrck", {31'd0, audio_lrck}, 32'd0, 0);
        compare("audio_dac", {31'd0, audio_dac}, 32'd0, 0);
        compare("underrun", {31'd0, underrun}, 32'd0, 0);
        compare("overrun", {31'd0, overrun}, 32'd0, 0);
        wait (reset_n);
        @(posedge audgen_mclk);
        #1;
        compare("audio_sclk", {31'd0, audio_sclk}, 32'd0, 0);
        compare("audio_lrck", {31'd0, audio_lrck}, 32'd0, 0);
        compare("audio_dac", {31'd0, audio_dac}, 32'd0, 0);
        compare("underrun", {31'd0, underrun}, 32'd0, 0);
        compare("overrun", {31'd0, overrun}, 32'd0, 0);
        report_test("reset values", 0);

        fork
            begin
                for (int f = 0; f < NF; f++) begin
                    @(posedge audio_lrck);
                    if (f < 40 || f == 42) begin
                        strobe_pair(f);
                    end else if (f == 41) begin
                        strobe_pair(f);
                        strobe_pair(f);
                        exp_over[f] = 1;
                    end else begin
                        // empty right half, silence and underrun next frame
                        exp_under[f+1] = 1;
                    end
                end
            end
            begin
                wait (dec_frames >= NF);
                report_test("data path", 2);
                wait (dec_frames > NF);
                report_test("underrun", 4);
                report_test("overrun", 5);
            end
        join

        report_test("clock ratio", 1);
        report_test("delay and pad slots", 3);
        errors = 0;
        for (int i = 0; i < 6; i++) errors += err_cnt[i];
        $display("tests 6, frames %0d, checks %0d, errors %0d", dec_frames, check_cnt, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
verilog/i2s_pkg.sv
verilog/sample_latch.sv
verilog/i2s_frame_timer.sv
verilog/i2s_serializer.sv
verilog/i2s_tx_top.sv
test/tb_clock_gen.sv
test/tb_i2s_tx.sv

/* run_sim.sh */
#!/bin/sh
# builds the i2s transmitter testbench with verilator and runs it
# exit status is 0 only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_i2s_tx \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_i2s_tx)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
